// File: verilog/xt_pkg.sv
`default_nettype none

package xt_pkg;

    // Widths
    localparam int DATA_W = 24;
    localparam int ADDR_W = 16;
    localparam int OPC_W  = 8;

    // Opcode class in the upper nibble
    localparam logic [3:0] OPCLASS_0 = 4'h0;
    localparam logic [3:0] OPCLASS_1 = 4'h1;
    localparam logic [3:0] OPCLASS_2 = 4'h2;
    localparam logic [3:0] OPCLASS_3 = 4'h3;
    localparam logic [3:0] OPCLASS_4 = 4'h4;
    localparam logic [3:0] OPCLASS_5 = 4'h5;
    localparam logic [3:0] OPCLASS_6 = 4'h6;
    localparam logic [3:0] OPCLASS_7 = 4'h7;
    localparam logic [3:0] OPCLASS_9 = 4'h9;
    localparam logic [3:0] OPCLASS_F = 4'hF;

    // Control-flow subops of class 6
    localparam logic [3:0] SUBOP_BTP   = 4'h0;
    localparam logic [3:0] SUBOP_JCCUI = 4'h1;
    localparam logic [3:0] SUBOP_BCCSR = 4'h2;
    localparam logic [3:0] SUBOP_BCCSO = 4'h3;
    localparam logic [3:0] SUBOP_BALSO = 4'h4;
    localparam logic [3:0] SUBOP_JSRUI = 4'h5;
    localparam logic [3:0] SUBOP_BSRSR = 4'h6;
    localparam logic [3:0] SUBOP_BSRSO = 4'h7;
    localparam logic [3:0] SUBOP_RET   = 4'h8;

    // Privileged subop of class 9
    localparam logic [3:0] SUBOP_SETSSP = 4'h3;

    // Full opcodes
    localparam logic [OPC_W-1:0] OPC_NOP      = 8'h00;
    localparam logic [OPC_W-1:0] OPC_CLDCSO   = 8'h4A;
    localparam logic [OPC_W-1:0] OPC_CSTCSO   = 8'h4B;
    localparam logic [OPC_W-1:0] OPC_CR2SR    = 8'h4C;
    localparam logic [OPC_W-1:0] OPC_SR2CR    = 8'h4D;
    localparam logic [OPC_W-1:0] OPC_SRADDSI  = 8'h50;
    localparam logic [OPC_W-1:0] OPC_SRSUBSI  = 8'h51;
    localparam logic [OPC_W-1:0] OPC_SRLDSO   = 8'h52;
    localparam logic [OPC_W-1:0] OPC_SRSTSO   = 8'h53;
    localparam logic [OPC_W-1:0] OPC_SRMOVUR  = 8'h54;
    localparam logic [OPC_W-1:0] OPC_SRMOVAUR = 8'h55;
    localparam logic [OPC_W-1:0] OPC_SRJCCSO  = 8'h56;
    localparam logic [OPC_W-1:0] OPC_JCCUI    = {OPCLASS_6, SUBOP_JCCUI};
    localparam logic [OPC_W-1:0] OPC_BCCSR    = {OPCLASS_6, SUBOP_BCCSR};
    localparam logic [OPC_W-1:0] OPC_BALSO    = {OPCLASS_6, SUBOP_BALSO};

    // Special registers
    localparam logic [1:0] SR_IDX_LR  = 2'd0;
    localparam logic [1:0] SR_IDX_SSP = 2'd1;
    localparam logic [1:0] SR_IDX_PC  = 2'd2;

    // Capability fields
    localparam logic [3:0] CR_FLD_BASE  = 4'd0;
    localparam logic [3:0] CR_FLD_LEN   = 4'd1;
    localparam logic [3:0] CR_FLD_CUR   = 4'd2;
    localparam logic [3:0] CR_FLD_PERMS = 4'd3;
    localparam logic [3:0] CR_FLD_ATTR  = 4'd4;
    localparam logic [3:0] CR_FLD_TAG   = 4'd5;

    // Each field slot is producer, NOP gap, consumer
    localparam int CAP_NOP_GAP  = 6;
    localparam int CAP_FIELDS   = 6;
    localparam int CAP_SLOT     = CAP_NOP_GAP + 2;
    // Two address setup micro-ops come first
    localparam int CAP_SEQ_LEN  = 2 + CAP_FIELDS * CAP_SLOT;
    localparam int CALL_SEQ_LEN = 4;
    localparam int RET_SEQ_LEN  = 3;
    localparam int SEQ_IDX_W    = 6;

    typedef enum logic [2:0] {
        SEQ_NONE,
        SEQ_JSR,
        SEQ_BSR_REG,
        SEQ_BSR_OFS,
        SEQ_RET,
        SEQ_CLD,
        SEQ_CST
    } xt_seq_kind_t;

    // One instruction word seen through its micro-op formats
    typedef union packed {
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [1:0]  tgt_sr;
            logic [13:0] imm14;
        } sr_imm14;
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [1:0]  tgt_sr;
            logic [1:0]  src_sr;
            logic [11:0] imm12;
        } sr_sr_imm12;
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [1:0]  tgt_sr;
            logic [3:0]  cc;
            logic [9:0]  imm10;
        } sr_cc_imm10;
        // CLD/CST keep CRt in tgt, CRs in src and the offset in the low 10 bits
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [1:0]  tgt;
            logic [1:0]  src;
            logic [3:0]  fld;
            logic [7:0]  pad;
        } cr_move;
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [3:0]  cc;
            logic [11:0] imm12;
        } cc_imm12;
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [3:0]  tgt_dr;
            logic [3:0]  cc;
            logic [7:0]  pad;
        } dr_cc;
        struct packed {
            struct packed {logic [3:0] opclass; logic [3:0] subop;} opc;
            logic [15:0] imm16;
        } imm16;
    } xt_word_t;

endpackage

`default_nettype wire

// File: verilog/xt_macro_decode.sv
`default_nettype none

module xt_macro_decode
    import xt_pkg::*;
(
    input  xt_word_t     instr,
    output xt_seq_kind_t seq_kind,
    output xt_word_t     direct_word
);

    logic [3:0]       opclass;
    logic [3:0]       subop;
    logic [OPC_W-1:0] opcode;

    assign opclass = instr.imm16.opc.opclass;
    assign subop   = instr.imm16.opc.subop;
    assign opcode  = instr.imm16.opc;

    always_comb begin
        seq_kind    = SEQ_NONE;
        direct_word = instr;
        case (opclass)
            OPCLASS_0, OPCLASS_1, OPCLASS_2, OPCLASS_3,
            OPCLASS_4, OPCLASS_5, OPCLASS_7, OPCLASS_F: begin
                // Capability moves expand, everything else passes
                if (opcode == OPC_CLDCSO) begin
                    seq_kind    = SEQ_CLD;
                    direct_word = '0;
                end else if (opcode == OPC_CSTCSO) begin
                    seq_kind    = SEQ_CST;
                    direct_word = '0;
                end
            end
            OPCLASS_6: begin
                case (subop)
                    SUBOP_BTP: begin
                        direct_word = '0;
                        direct_word.imm16.opc = OPC_NOP;
                    end
                    SUBOP_JCCUI, SUBOP_BCCSR, SUBOP_BCCSO, SUBOP_BALSO: begin
                        direct_word = instr;
                    end
                    SUBOP_JSRUI: begin
                        seq_kind    = SEQ_JSR;
                        direct_word = '0;
                    end
                    SUBOP_BSRSR: begin
                        seq_kind    = SEQ_BSR_REG;
                        direct_word = '0;
                    end
                    SUBOP_BSRSO: begin
                        seq_kind    = SEQ_BSR_OFS;
                        direct_word = '0;
                    end
                    SUBOP_RET: begin
                        seq_kind    = SEQ_RET;
                        direct_word = '0;
                    end
                    // Unknown control flow becomes a NOP
                    default: begin
                        direct_word = '0;
                    end
                endcase
            end
            OPCLASS_9: begin
                // SETSSP is a move of the source SR into SSP
                if (subop == SUBOP_SETSSP) begin
                    direct_word                    = '0;
                    direct_word.sr_sr_imm12.opc    = OPC_SRMOVAUR;
                    direct_word.sr_sr_imm12.tgt_sr = SR_IDX_SSP;
                    direct_word.sr_sr_imm12.src_sr = instr.sr_sr_imm12.tgt_sr;
                end
            end
            default: begin
                direct_word = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/xt_uop_gen.sv
`default_nettype none

module xt_uop_gen
    import xt_pkg::*;
(
    input  xt_seq_kind_t         kind,
    input  logic [SEQ_IDX_W-1:0] idx,
    input  xt_word_t             macro,
    output xt_word_t             uop,
    output logic                 uop_last
);

    logic [SEQ_IDX_W-1:0] cap_rel;
    logic [2:0]           fld_k;
    logic [2:0]           slot_s;
    logic [3:0]           fld_code;
    logic [11:0]          fld_ofs;
    logic [13:0]          ea_ofs;

    // Field order of a capability transfer
    function automatic logic [3:0] cap_field(input logic [2:0] k);
        case (k)
            3'd0:    cap_field = CR_FLD_BASE;
            3'd1:    cap_field = CR_FLD_LEN;
            3'd2:    cap_field = CR_FLD_CUR;
            3'd3:    cap_field = CR_FLD_PERMS;
            3'd4:    cap_field = CR_FLD_ATTR;
            default: cap_field = CR_FLD_TAG;
        endcase
    endfunction

    // Field slots start after the two address setup micro-ops
    assign cap_rel  = idx - SEQ_IDX_W'(2);
    assign fld_k    = 3'(cap_rel / CAP_SLOT);
    assign slot_s   = 3'(cap_rel % CAP_SLOT);
    assign fld_code = cap_field(fld_k);
    // Fields sit two bytes apart in memory
    assign fld_ofs  = {8'b0, fld_k, 1'b0};
    assign ea_ofs   = {{4{macro.sr_cc_imm10.imm10[9]}}, macro.sr_cc_imm10.imm10};

    always_comb begin
        uop      = '0;
        uop_last = 1'b0;
        case (kind)
            SEQ_JSR, SEQ_BSR_REG, SEQ_BSR_OFS: begin
                uop_last = (idx == SEQ_IDX_W'(CALL_SEQ_LEN - 1));
                case (idx)
                    'd0: begin
                        uop.sr_imm14.opc    = OPC_SRSUBSI;
                        uop.sr_imm14.tgt_sr = SR_IDX_SSP;
                        uop.sr_imm14.imm14  = 14'd2;
                    end
                    'd1: begin
                        uop.sr_sr_imm12.opc    = OPC_SRSTSO;
                        uop.sr_sr_imm12.tgt_sr = SR_IDX_SSP;
                        uop.sr_sr_imm12.src_sr = SR_IDX_LR;
                    end
                    'd2: begin
                        uop.sr_sr_imm12.opc    = OPC_SRMOVUR;
                        uop.sr_sr_imm12.tgt_sr = SR_IDX_LR;
                        uop.sr_sr_imm12.src_sr = SR_IDX_PC;
                    end
                    'd3: begin
                        if (kind == SEQ_JSR) begin
                            uop.cc_imm12.opc   = OPC_JCCUI;
                            uop.cc_imm12.imm12 = macro.cc_imm12.imm12;
                        end else if (kind == SEQ_BSR_REG) begin
                            uop.dr_cc.opc    = OPC_BCCSR;
                            uop.dr_cc.tgt_dr = macro.dr_cc.tgt_dr;
                        end else begin
                            uop.imm16.opc   = OPC_BALSO;
                            uop.imm16.imm16 = macro.imm16.imm16;
                        end
                    end
                    default: uop = '0;
                endcase
            end
            SEQ_RET: begin
                uop_last = (idx == SEQ_IDX_W'(RET_SEQ_LEN - 1));
                case (idx)
                    'd0: begin
                        uop.sr_imm14.opc    = OPC_SRADDSI;
                        uop.sr_imm14.tgt_sr = SR_IDX_SSP;
                        uop.sr_imm14.imm14  = 14'd2;
                    end
                    'd1: begin
                        // Return address sits just below the popped SSP
                        uop.sr_sr_imm12.opc    = OPC_SRLDSO;
                        uop.sr_sr_imm12.tgt_sr = SR_IDX_LR;
                        uop.sr_sr_imm12.src_sr = SR_IDX_SSP;
                        uop.sr_sr_imm12.imm12  = 12'hFFE;
                    end
                    'd2: begin
                        uop.sr_cc_imm10.opc    = OPC_SRJCCSO;
                        uop.sr_cc_imm10.tgt_sr = SR_IDX_LR;
                        uop.sr_cc_imm10.imm10  = 10'd1;
                    end
                    default: uop = '0;
                endcase
            end
            SEQ_CLD, SEQ_CST: begin
                uop_last = (idx == SEQ_IDX_W'(CAP_SEQ_LEN - 1));
                if (idx == SEQ_IDX_W'(0)) begin
                    // LR gets the cursor of the memory-side capability
                    uop.cr_move.opc = OPC_CR2SR;
                    uop.cr_move.tgt = SR_IDX_LR;
                    uop.cr_move.src = (kind == SEQ_CLD) ? macro.cr_move.src : macro.cr_move.tgt;
                    uop.cr_move.fld = CR_FLD_CUR;
                end else if (idx == SEQ_IDX_W'(1)) begin
                    uop.sr_imm14.opc    = OPC_SRADDSI;
                    uop.sr_imm14.tgt_sr = SR_IDX_LR;
                    uop.sr_imm14.imm14  = ea_ofs;
                end else if (slot_s == 3'd0) begin
                    if (kind == SEQ_CLD) begin
                        uop.sr_sr_imm12.opc    = OPC_SRLDSO;
                        uop.sr_sr_imm12.tgt_sr = SR_IDX_SSP;
                        uop.sr_sr_imm12.src_sr = SR_IDX_LR;
                        uop.sr_sr_imm12.imm12  = fld_ofs;
                    end else begin
                        uop.cr_move.opc = OPC_CR2SR;
                        uop.cr_move.tgt = SR_IDX_SSP;
                        uop.cr_move.src = macro.cr_move.src;
                        uop.cr_move.fld = fld_code;
                    end
                end else if (slot_s == 3'(CAP_NOP_GAP + 1)) begin
                    if (kind == SEQ_CLD) begin
                        uop.cr_move.opc = OPC_SR2CR;
                        uop.cr_move.tgt = macro.cr_move.tgt;
                        uop.cr_move.src = SR_IDX_SSP;
                        uop.cr_move.fld = fld_code;
                    end else begin
                        uop.sr_sr_imm12.opc    = OPC_SRSTSO;
                        uop.sr_sr_imm12.tgt_sr = SR_IDX_LR;
                        uop.sr_sr_imm12.src_sr = SR_IDX_SSP;
                        uop.sr_sr_imm12.imm12  = fld_ofs;
                    end
                end
                // Gap slots stay all zero
            end
            default: begin
                uop      = '0;
                uop_last = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/xt_sequencer.sv
`default_nettype none

module xt_sequencer
    import xt_pkg::*;
(
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic [ADDR_W-1:0]    pc,
    input  xt_word_t             instr,
    input  logic                 flush,
    input  logic                 stall,
    input  xt_seq_kind_t         seq_kind,
    input  xt_word_t             direct_word,
    input  xt_word_t             uop,
    input  logic                 uop_last,
    output xt_seq_kind_t         gen_kind,
    output logic [SEQ_IDX_W-1:0] gen_idx,
    output xt_word_t             gen_word,
    output logic [ADDR_W-1:0]    out_pc,
    output xt_word_t             out_instr,
    output logic                 hold
);

    logic                 busy;
    logic [SEQ_IDX_W-1:0] idx;
    xt_seq_kind_t         kind_q;
    xt_word_t             macro_q;
    logic [ADDR_W-1:0]    pc_q;

    logic                 advance;
    logic                 start;
    logic [ADDR_W-1:0]    next_pc;
    xt_word_t             next_instr;

    // Generator works on the held macro while busy, else on the live word
    assign gen_kind = busy ? kind_q : seq_kind;
    assign gen_idx  = busy ? idx : '0;
    assign gen_word = busy ? macro_q : instr;

    assign advance = !flush && !stall;
    assign start   = !busy && (seq_kind != SEQ_NONE);

    // All micro-ops of a sequence carry the macro PC
    assign next_pc    = busy ? pc_q : pc;
    assign next_instr = (busy || start) ? uop : direct_word;

    // Upstream keeps its word while the rest of the sequence is emitted
    assign hold = busy;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            busy      <= 1'b0;
            idx       <= '0;
            kind_q    <= SEQ_NONE;
            out_pc    <= '0;
            out_instr <= '0;
        end else if (flush) begin
            busy      <= 1'b0;
            idx       <= '0;
            kind_q    <= SEQ_NONE;
            out_pc    <= '0;
            out_instr <= '0;
        end else if (!stall) begin
            out_pc    <= next_pc;
            out_instr <= next_instr;
            if (busy) begin
                if (uop_last) begin
                    busy   <= 1'b0;
                    idx    <= '0;
                    kind_q <= SEQ_NONE;
                end else begin
                    idx <= idx + SEQ_IDX_W'(1);
                end
            end else if (start) begin
                // Micro-op 0 goes out now, the rest follow from index 1
                busy   <= 1'b1;
                idx    <= SEQ_IDX_W'(1);
                kind_q <= seq_kind;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        if (advance && start) begin
            macro_q <= instr;
            pc_q    <= pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/xt_stage.sv
`default_nettype none

module xt_stage
    import xt_pkg::*;
(
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic [ADDR_W-1:0] iw_pc,
    input  logic [DATA_W-1:0] iw_instr,
    input  logic              iw_flush,
    input  logic              iw_stall,
    output logic [ADDR_W-1:0] ow_pc,
    output logic [DATA_W-1:0] ow_instr,
    output logic              ow_hold
);

    xt_seq_kind_t         seq_kind;
    xt_word_t             direct_word;
    xt_seq_kind_t         gen_kind;
    logic [SEQ_IDX_W-1:0] gen_idx;
    xt_word_t             gen_word;
    xt_word_t             uop;
    logic                 uop_last;

    xt_macro_decode u_decode (
        .instr       (iw_instr),
        .seq_kind    (seq_kind),
        .direct_word (direct_word)
    );

    xt_uop_gen u_gen (
        .kind     (gen_kind),
        .idx      (gen_idx),
        .macro    (gen_word),
        .uop      (uop),
        .uop_last (uop_last)
    );

    xt_sequencer u_seq (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .pc          (iw_pc),
        .instr       (iw_instr),
        .flush       (iw_flush),
        .stall       (iw_stall),
        .seq_kind    (seq_kind),
        .direct_word (direct_word),
        .uop         (uop),
        .uop_last    (uop_last),
        .gen_kind    (gen_kind),
        .gen_idx     (gen_idx),
        .gen_word    (gen_word),
        .out_pc      (ow_pc),
        .out_instr   (ow_instr),
        .hold        (ow_hold)
    );

endmodule

`default_nettype wire

// File: test/xt_tb_ref.svh
`ifndef XT_TB_REF_SVH
`define XT_TB_REF_SVH

// Number of output words a macro instruction turns into
function automatic int seq_length(input logic [DATA_W-1:0] w);
    logic [3:0] cls;
    logic [3:0] sub;
    cls = w[23:20];
    sub = w[19:16];
    if (w[23:16] == OPC_CLDCSO || w[23:16] == OPC_CSTCSO) begin
        return CAP_SEQ_LEN;
    end
    if (cls == OPCLASS_6 && (sub == SUBOP_JSRUI || sub == SUBOP_BSRSR || sub == SUBOP_BSRSO)) begin
        return CALL_SEQ_LEN;
    end
    if (cls == OPCLASS_6 && sub == SUBOP_RET) begin
        return RET_SEQ_LEN;
    end
    return 1;
endfunction

// Single-word translation of non-sequence instructions
function automatic logic [DATA_W-1:0] direct_replacement(input logic [DATA_W-1:0] w);
    logic [3:0] cls;
    logic [3:0] sub;
    cls = w[23:20];
    sub = w[19:16];
    case (cls)
        OPCLASS_0, OPCLASS_1, OPCLASS_2, OPCLASS_3,
        OPCLASS_4, OPCLASS_5, OPCLASS_7, OPCLASS_F: return w;
        OPCLASS_6: begin
            if (sub == SUBOP_JCCUI || sub == SUBOP_BCCSR || sub == SUBOP_BCCSO ||
                sub == SUBOP_BALSO) begin
                return w;
            end
            // BTP and unknown subops end up as the NOP word
            return '0;
        end
        OPCLASS_9: begin
            if (sub == SUBOP_SETSSP) begin
                return {OPC_SRMOVAUR, SR_IDX_SSP, w[15:14], 12'h000};
            end
            return w;
        end
        default: return '0;
    endcase
endfunction

// Capability fields in transfer order
function automatic logic [3:0] field_code(input int k);
    case (k)
        0: return CR_FLD_BASE;
        1: return CR_FLD_LEN;
        2: return CR_FLD_CUR;
        3: return CR_FLD_PERMS;
        4: return CR_FLD_ATTR;
        default: return CR_FLD_TAG;
    endcase
endfunction

// Expected output word number i for macro word w
function automatic logic [DATA_W-1:0] expected_uop(input logic [DATA_W-1:0] w, input int i);
    logic [7:0]  opc;
    logic [3:0]  sub;
    logic        is_cld;
    logic [11:0] ofs;
    int          k;
    int          s;
    opc = w[23:16];
    sub = w[19:16];
    if (seq_length(w) == 1) begin
        return direct_replacement(w);
    end
    if (opc == OPC_CLDCSO || opc == OPC_CSTCSO) begin
        is_cld = (opc == OPC_CLDCSO);
        if (i == 0) begin
            return {OPC_CR2SR, SR_IDX_LR, is_cld ? w[13:12] : w[15:14], CR_FLD_CUR, 8'h00};
        end
        if (i == 1) begin
            return {OPC_SRADDSI, SR_IDX_LR, {4{w[9]}}, w[9:0]};
        end
        k = (i - 2) / CAP_SLOT;
        s = (i - 2) % CAP_SLOT;
        ofs = 12'(2 * k);
        if (s == 0) begin
            if (is_cld) begin
                return {OPC_SRLDSO, SR_IDX_SSP, SR_IDX_LR, ofs};
            end
            return {OPC_CR2SR, SR_IDX_SSP, w[13:12], field_code(k), 8'h00};
        end
        if (s == CAP_SLOT - 1) begin
            if (is_cld) begin
                return {OPC_SR2CR, w[15:14], SR_IDX_SSP, field_code(k), 8'h00};
            end
            return {OPC_SRSTSO, SR_IDX_LR, SR_IDX_SSP, ofs};
        end
        return '0;
    end
    if (sub == SUBOP_RET) begin
        case (i)
            0: return {OPC_SRADDSI, SR_IDX_SSP, 14'd2};
            1: return {OPC_SRLDSO, SR_IDX_LR, SR_IDX_SSP, 12'hFFE};
            default: return {OPC_SRJCCSO, SR_IDX_LR, 4'h0, 10'd1};
        endcase
    end
    // Subroutine calls push LR, save the return PC, then branch
    case (i)
        0: return {OPC_SRSUBSI, SR_IDX_SSP, 14'd2};
        1: return {OPC_SRSTSO, SR_IDX_SSP, SR_IDX_LR, 12'h000};
        2: return {OPC_SRMOVUR, SR_IDX_LR, SR_IDX_PC, 12'h000};
        default: begin
            if (sub == SUBOP_JSRUI) begin
                return {OPC_JCCUI, 4'h0, w[11:0]};
            end
            if (sub == SUBOP_BSRSR) begin
                return {OPC_BCCSR, w[15:12], 4'h0, 8'h00};
            end
            return {OPC_BALSO, w[15:0]};
        end
    endcase
endfunction

`endif

// File: test/xt_tb.sv
`default_nettype none

module xt_tb
    import xt_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS = 16;

    logic              iw_clk;
    logic              iw_rst;
    logic [ADDR_W-1:0] iw_pc;
    logic [DATA_W-1:0] iw_instr;
    logic              iw_flush;
    logic              iw_stall;
    logic [ADDR_W-1:0] ow_pc;
    logic [DATA_W-1:0] ow_instr;
    logic              ow_hold;

    int seed = 32'h2156_c86a;
    int cycles = 0;
    int limit;

    // Last expected output, which a stall must leave in place
    logic [DATA_W-1:0] last_instr;
    logic [ADDR_W-1:0] last_pc;
    logic              last_hold;

    // Name, PC, word, stall percent, flush index
    string test_name [NROWS] = '{
        "pass_alu", "btp_nop", "setssp", "unknown_class",
        "unknown_cf", "jsrui", "bsrsr", "bsrso",
        "ret", "cldcso", "cstcso", "jsr_stall",
        "cld_stall", "cld_flush", "pass_after_flush", "ret_stall"
    };
    logic [ADDR_W-1:0] row_pc [NROWS] = '{
        16'h0100, 16'h0102, 16'h0104, 16'h0106,
        16'h0108, 16'h0200, 16'h0204, 16'h0208,
        16'h020C, 16'h0300, 16'h0304, 16'h0400,
        16'h0404, 16'h0408, 16'h040C, 16'h0410
    };
    logic [DATA_W-1:0] row_word [NROWS] = '{
        24'h123456, 24'h60BEEF, 24'h939234, 24'h8A5555,
        24'h6C1234, 24'h650ABC, 24'h667000, 24'h671234,
        24'h680000, 24'h4A9FF8, 24'h4BC014, 24'h650123,
        24'h4A6005, 24'h4A9FF8, 24'h2F00AA, 24'h680000
    };
    int row_stall [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 40, 30, 0, 0, 50};
    int row_flush [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 26, 0, 0};

    `include "xt_tb_ref.svh"

    xt_stage DUT (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .iw_pc    (iw_pc),
        .iw_instr (iw_instr),
        .iw_flush (iw_flush),
        .iw_stall (iw_stall),
        .ow_pc    (ow_pc),
        .ow_instr (ow_instr),
        .ow_hold  (ow_hold)
    );

    initial begin
        iw_clk = 1'b0;
        forever #2 iw_clk = ~iw_clk;
    end

    // Cycle budget grows with the total sequence length
    initial begin
        limit = 100;
        for (int r = 0; r < NROWS; r++) begin
            limit += 4 * seq_length(row_word[r]);
        end
        forever begin
            @(posedge iw_clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: the run did not finish within %0d cycles", limit);
                $display("TEST FAILED");
                $fatal(1);
            end
        end
    end

    task automatic check_value(input string what, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", what, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge iw_clk);
        #1;
    endtask

    // Holds the word until the whole stream is out, or until the flush
    task automatic apply_row(input int r);
        int                len;
        int                n;
        bit                done;
        logic              stall_now;
        logic              flush_now;
        string             tag;
        len  = seq_length(row_word[r]);
        n    = 0;
        done = 1'b0;
        iw_pc    = row_pc[r];
        iw_instr = row_word[r];
        while (!done) begin
            flush_now = (row_flush[r] != 0) && (n == row_flush[r]);
            stall_now = !flush_now && (row_stall[r] > 0) &&
                        (($unsigned($random(seed)) % 100) < row_stall[r]);
            iw_flush   = flush_now;
            iw_stall   = stall_now;
            next_cycle();
            tag = $sformatf("%s uop %0d", test_name[r], n);
            if (flush_now) begin
                check_value({tag, " flush instr"}, '0, ow_instr);
                check_value({tag, " flush pc"}, '0, DATA_W'(ow_pc));
                check_value({tag, " flush hold"}, '0, DATA_W'(ow_hold));
                last_instr = '0;
                last_pc    = '0;
                last_hold  = 1'b0;
                done = 1'b1;
            end else if (stall_now) begin
                check_value({tag, " stall instr"}, last_instr, ow_instr);
                check_value({tag, " stall pc"}, DATA_W'(last_pc), DATA_W'(ow_pc));
                check_value({tag, " stall hold"}, DATA_W'(last_hold), DATA_W'(ow_hold));
            end else begin
                last_instr = expected_uop(row_word[r], n);
                last_pc    = row_pc[r];
                last_hold  = (n < len - 1);
                check_value({tag, " instr"}, last_instr, ow_instr);
                check_value({tag, " pc"}, DATA_W'(last_pc), DATA_W'(ow_pc));
                check_value({tag, " hold"}, DATA_W'(last_hold), DATA_W'(ow_hold));
                n++;
                done = (n == len);
            end
        end
        iw_flush = 1'b0;
        iw_stall = 1'b0;
    endtask

    initial begin
        iw_rst     = 1'b1;
        iw_pc      = '0;
        iw_instr   = '0;
        iw_flush   = 1'b0;
        iw_stall   = 1'b0;
        last_instr = '0;
        last_pc    = '0;
        last_hold  = 1'b0;
        repeat (3) @(posedge iw_clk);
        #1;
        iw_rst = 1'b0;
        check_value("reset instr", '0, ow_instr);
        check_value("reset pc", '0, DATA_W'(ow_pc));
        check_value("reset hold", '0, DATA_W'(ow_hold));
        for (int r = 0; r < NROWS; r++) begin
            apply_row(r);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+test
verilog/xt_pkg.sv
verilog/xt_macro_decode.sv
verilog/xt_uop_gen.sv
verilog/xt_sequencer.sv
verilog/xt_stage.sv
test/xt_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module xt_tb -o xt_sim

# The simulator exits non-zero on failure, the log search decides the result
./obj_dir/xt_sim | tee sim.log

grep -q "^TEST OK$" sim.log
